//--- amo_pkg.sv
/*
  Shared types and constants for the atomic unit.
  Memory is word addressed; one word is XLEN bits and 32-bit operations use the
  low half. RSV_CNT_W must be wide enough to hold RSV_CYCLES.
*/
package amo_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 64;
  localparam int unsigned MEM_WORDS  = 16;
  localparam int unsigned ADDR_W     = 4;
  localparam int unsigned RSV_CYCLES = 32;
  localparam int unsigned RSV_CNT_W  = 6;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    AMO_LR   = 4'd0,
    AMO_SC   = 4'd1,
    AMO_SWAP = 4'd2,
    AMO_ADD  = 4'd3,
    AMO_AND  = 4'd4,
    AMO_OR   = 4'd5,
    AMO_XOR  = 4'd6,
    AMO_MAX  = 4'd7,
    AMO_MIN  = 4'd8,
    AMO_MAXU = 4'd9,
    AMO_MINU = 4'd10
  } amo_op_e;

  typedef enum logic {
    SIZE_W = 1'b0,
    SIZE_D = 1'b1
  } amo_size_e;

  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    READ  = 3'd1,
    EXEC  = 3'd2,
    WRITE = 3'd3,
    ACK   = 3'd4
  } amo_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    amo_op_e             op;
    amo_size_e           size;
    logic [ADDR_W-1:0]   addr;
    logic [XLEN-1:0]     operand;
  } amo_req_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
  } amo_resp_t;

  // Store value, returned value and the store enable
  typedef struct packed {
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;
    logic            we;
  } alu_out_t;

endpackage

//--- amo_mem.sv
/*
  Word memory, cleared by reset. Read data is valid one cycle after rd_i.
  A 32-bit write touches only the low half of the addressed word.
*/
module amo_mem (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        rd_i,
  input  logic [amo_pkg::ADDR_W-1:0]  addr_i,
  input  logic                        we_i,
  input  amo_pkg::amo_size_e          size_i,
  input  logic [amo_pkg::XLEN-1:0]    wdata_i,
  output logic [amo_pkg::XLEN-1:0]    rdata_o
);
  import amo_pkg::*;

  logic [XLEN-1:0] mem_q [MEM_WORDS];
  logic [XLEN-1:0] rdata_q;

  // Write port
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      if (size_i == SIZE_D) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        // Upper half keeps its old contents
        mem_q[addr_i][XLEN/2-1:0] <= wdata_i[XLEN/2-1:0];
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- amo_alu.sv
/*
  Combinational datapath for one atomic operation.
  32-bit operations sign-extend both operands; MAXU and MINU compare the
  zero-extended halves. rsv_hit_i decides SC success.
*/
module amo_alu (
  input  amo_pkg::amo_req_t            req_i,
  input  logic [amo_pkg::XLEN-1:0]     mem_i,
  input  logic                         rsv_hit_i,
  output amo_pkg::alu_out_t            out_o
);
  import amo_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] op_a_u;
  logic [XLEN-1:0] op_b_u;
  logic            lt_s;
  logic            lt_u;

  ////////////////////////////////////////////////////////////////////////////
  // Operand extension
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (req_i.size == SIZE_W) begin
      op_a   = {{(XLEN/2){mem_i[XLEN/2-1]}}, mem_i[XLEN/2-1:0]};
      op_b   = {{(XLEN/2){req_i.operand[XLEN/2-1]}}, req_i.operand[XLEN/2-1:0]};
      op_a_u = {{(XLEN/2){1'b0}}, mem_i[XLEN/2-1:0]};
      op_b_u = {{(XLEN/2){1'b0}}, req_i.operand[XLEN/2-1:0]};
    end else begin
      op_a   = mem_i;
      op_b   = req_i.operand;
      op_a_u = mem_i;
      op_b_u = req_i.operand;
    end
  end

  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a_u < op_b_u;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Most operations return the old value and store a new one
    out_o.rdata = op_a;
    out_o.we    = 1'b1;
    case (req_i.op)
      AMO_LR: begin
        out_o.wdata = op_a;
        out_o.we    = 1'b0;
      end
      AMO_SC: begin
        out_o.wdata = op_b;
        out_o.rdata = rsv_hit_i ? '0 : XLEN'(1);
        out_o.we    = rsv_hit_i;
      end
      AMO_SWAP: out_o.wdata = op_b;
      AMO_ADD:  out_o.wdata = op_a + op_b;
      AMO_AND:  out_o.wdata = op_a & op_b;
      AMO_OR:   out_o.wdata = op_a | op_b;
      AMO_XOR:  out_o.wdata = op_a ^ op_b;
      AMO_MAX:  out_o.wdata = lt_s ? op_b : op_a;
      AMO_MIN:  out_o.wdata = lt_s ? op_a : op_b;
      AMO_MAXU: out_o.wdata = lt_u ? op_b : op_a;
      AMO_MINU: out_o.wdata = lt_u ? op_a : op_b;
      default: begin
        out_o.wdata = op_a;
        out_o.we    = 1'b0;
      end
    endcase
  end

endmodule

//--- rsv_timer.sv
/*
  LR reservation with a bounded lifetime of RSV_CYCLES clock cycles.
  Set and clear act on the next edge; set wins over clear.
*/
module rsv_timer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        set_i,
  input  logic                        clear_i,
  input  logic [amo_pkg::ADDR_W-1:0]  addr_i,
  output logic                        hit_o
);
  import amo_pkg::*;

  logic [RSV_CNT_W-1:0] cnt_q;
  logic [ADDR_W-1:0]    addr_q;
  logic                 valid;

  // Reservation lives as long as the counter is non-zero
  assign valid = (cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (set_i) begin
      cnt_q <= RSV_CNT_W'(RSV_CYCLES);
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (valid) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Reserved address
  always_ff @(posedge clk_i) begin
    if (set_i) begin
      addr_q <= addr_i;
    end
  end

  assign hit_o = valid && (addr_q == addr_i);

endmodule

//--- amo_fsm.sv
/*
  Sequencer for one atomic operation at a time behind a four-phase req/ack port.
  req_data_i is sampled in IDLE only. ack_o rises four edges after the request
  is taken and falls on the first edge with req_i low.
*/
module amo_fsm (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  amo_pkg::amo_req_t         req_data_i,
  input  amo_pkg::alu_out_t         alu_i,
  output logic                      mem_rd_o,
  output logic                      mem_we_o,
  output logic [amo_pkg::XLEN-1:0]  mem_wdata_o,
  output amo_pkg::amo_req_t         lat_req_o,
  output logic                      rsv_set_o,
  output logic                      rsv_clear_o,
  output logic                      ack_o,
  output amo_pkg::amo_resp_t        resp_o
);
  import amo_pkg::*;

  amo_state_e state_q;
  amo_state_e state_d;
  amo_req_t   req_q;
  alu_out_t   alu_q;
  logic       ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_i) state_d = READ;
      READ:    state_d = EXEC;
      EXEC:    state_d = WRITE;
      WRITE:   state_d = ACK;
      // Leave only once the requester has seen ack and released req
      ACK:     if (ack_q && !req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ACK) begin
        ack_q <= req_i || !ack_q;
      end
    end
  end

  // Request and ALU result registers
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      req_q <= req_data_i;
    end
    if (state_q == EXEC) begin
      alu_q <= alu_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign mem_rd_o    = (state_q == READ);
  assign mem_we_o    = (state_q == WRITE) && alu_q.we;
  assign mem_wdata_o = alu_q.wdata;
  assign lat_req_o   = req_q;

  // Reservation update lands on the same edge as the ALU result
  assign rsv_set_o   = (state_q == EXEC) && (req_q.op == AMO_LR);
  assign rsv_clear_o = (state_q == EXEC) && (req_q.op == AMO_SC);

  assign ack_o       = ack_q;
  assign resp_o.data = alu_q.rdata;

endmodule

//--- amo_unit.sv
/*
  Atomic memory unit: LR/SC and read-modify-write AMOs on a small word memory.
  Only one request is in flight; the requester must follow the four-phase
  req/ack handshake and hold req_data_i stable while req_i is high.
*/
module amo_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  amo_pkg::amo_req_t   req_data_i,
  output logic                ack_o,
  output amo_pkg::amo_resp_t  resp_o
);
  import amo_pkg::*;

  amo_req_t        lat_req;
  alu_out_t        alu_out;
  logic            mem_rd;
  logic            mem_we;
  logic [XLEN-1:0] mem_wdata;
  logic [XLEN-1:0] mem_rdata;
  logic            rsv_set;
  logic            rsv_clear;
  logic            rsv_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  amo_fsm i_fsm (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .req_i       ( req_i      ),
    .req_data_i  ( req_data_i ),
    .alu_i       ( alu_out    ),
    .mem_rd_o    ( mem_rd     ),
    .mem_we_o    ( mem_we     ),
    .mem_wdata_o ( mem_wdata  ),
    .lat_req_o   ( lat_req    ),
    .rsv_set_o   ( rsv_set    ),
    .rsv_clear_o ( rsv_clear  ),
    .ack_o       ( ack_o      ),
    .resp_o      ( resp_o     )
  );

  rsv_timer i_rsv_timer (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .set_i   ( rsv_set      ),
    .clear_i ( rsv_clear    ),
    .addr_i  ( lat_req.addr ),
    .hit_o   ( rsv_hit      )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  amo_alu i_alu (
    .req_i     ( lat_req   ),
    .mem_i     ( mem_rdata ),
    .rsv_hit_i ( rsv_hit   ),
    .out_o     ( alu_out   )
  );

  amo_mem i_mem (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .rd_i    ( mem_rd       ),
    .addr_i  ( lat_req.addr ),
    .we_i    ( mem_we       ),
    .size_i  ( lat_req.size ),
    .wdata_i ( mem_wdata    ),
    .rdata_o ( mem_rdata    )
  );

endmodule

//--- tb_amo_unit.sv
/*
  Testbench for amo_unit. A directed table runs first, then 200 random requests.
  Every response is checked against a shadow memory and reservation model.
  Inputs change on falling edges and outputs are sampled there too.
*/
module tb_amo_unit;
  timeunit 1ns;
  timeprecision 1ps;
  import amo_pkg::*;

  typedef struct packed {
    amo_req_t        req;
    int              gap;
    int              hold;
    logic [XLEN-1:0] exp;
  } step_t;

  localparam int N_STEPS    = 28;
  localparam int N_RAND     = 200;
  localparam int MAX_CYCLES = (N_STEPS + N_RAND + int'(MEM_WORDS)) * 20;

  logic              clk_i = 1'b0;
  logic              rst_n_i;
  logic              req_i;
  amo_req_t          req_data_i;
  logic              ack_o;
  amo_resp_t         resp_o;
  int                cycles = 0;
  logic [XLEN-1:0]   shadow [MEM_WORDS];
  logic              rsv_valid;
  logic [ADDR_W-1:0] rsv_addr;
  int                rsv_edge;
  amo_req_t          rq;
  amo_resp_t         got;

  // Request, idle gap before it, extra cycles req_i is held after ack, expected data
  step_t steps [N_STEPS] = '{
    '{'{AMO_SWAP, SIZE_D, 4'd1, 64'h10}, 0, 0, 64'h0},
    '{'{AMO_ADD,  SIZE_D, 4'd1, 64'h5}, 0, 0, 64'h10},
    '{'{AMO_AND,  SIZE_D, 4'd1, 64'hC}, 0, 0, 64'h15},
    '{'{AMO_OR,   SIZE_D, 4'd1, 64'h30}, 0, 0, 64'h4},
    '{'{AMO_XOR,  SIZE_D, 4'd1, 64'hFF}, 0, 0, 64'h34},
    '{'{AMO_MAX,  SIZE_D, 4'd1, '1}, 0, 0, 64'hCB},
    '{'{AMO_MAXU, SIZE_D, 4'd1, '1}, 0, 0, 64'hCB},
    '{'{AMO_MIN,  SIZE_D, 4'd1, 64'h7}, 0, 0, '1},
    '{'{AMO_MINU, SIZE_D, 4'd1, 64'h7}, 0, 0, '1},
    '{'{AMO_OR,   SIZE_D, 4'd1, 64'h0}, 0, 0, 64'h7},
    // 32-bit operations on a negative low half
    '{'{AMO_SWAP, SIZE_D, 4'd2, 64'h1234_5678_FFFF_FFF0}, 0, 0, 64'h0},
    '{'{AMO_MAXU, SIZE_W, 4'd2, 64'h5}, 0, 0, 64'hFFFF_FFFF_FFFF_FFF0},
    '{'{AMO_MIN,  SIZE_W, 4'd2, 64'h5}, 0, 0, 64'hFFFF_FFFF_FFFF_FFF0},
    '{'{AMO_MAX,  SIZE_W, 4'd2, 64'h5}, 0, 0, 64'hFFFF_FFFF_FFFF_FFF0},
    '{'{AMO_MINU, SIZE_W, 4'd2, 64'hFFFF_FFF0}, 0, 0, 64'h5},
    '{'{AMO_ADD,  SIZE_W, 4'd2, 64'hDEAD_BEEF_FFFF_FFF0}, 0, 0, 64'h5},
    '{'{AMO_OR,   SIZE_D, 4'd2, 64'h0}, 0, 0, 64'h1234_5678_FFFF_FFF5},
    // LR/SC pairs, wrong address and expired reservation
    '{'{AMO_LR,   SIZE_D, 4'd3, 64'h0}, 0, 0, 64'h0},
    '{'{AMO_SC,   SIZE_D, 4'd3, 64'hCAFE}, 0, 0, 64'h0},
    '{'{AMO_SC,   SIZE_D, 4'd3, 64'hBEEF}, 0, 0, 64'h1},
    '{'{AMO_LR,   SIZE_D, 4'd3, 64'h0}, 0, 0, 64'hCAFE},
    '{'{AMO_SC,   SIZE_D, 4'd4, 64'h1111}, 0, 0, 64'h1},
    '{'{AMO_LR,   SIZE_D, 4'd3, 64'h0}, 0, 0, 64'hCAFE},
    '{'{AMO_SC,   SIZE_D, 4'd3, 64'h2222}, 2 * RSV_CYCLES, 0, 64'h1},
    '{'{AMO_OR,   SIZE_D, 4'd4, 64'h0}, 0, 0, 64'h0},
    '{'{AMO_OR,   SIZE_D, 4'd3, 64'h0}, 0, 0, 64'hCAFE},
    // Requester holds req_i after ack
    '{'{AMO_ADD,  SIZE_D, 4'd5, 64'h3}, 0, 3, 64'h0},
    '{'{AMO_OR,   SIZE_D, 4'd5, 64'h0}, 0, 0, 64'h3}
  };

  amo_unit UUT (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .req_i      ( req_i      ),
    .req_data_i ( req_data_i ),
    .ack_o      ( ack_o      ),
    .resp_o     ( resp_o     )
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles, DUT stopped answering", MAX_CYCLES));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_resp(input string name, input amo_resp_t got_v, input amo_resp_t exp_v);
    if (got_v !== exp_v) begin
      abort_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got_v, exp_v));
    end
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got_v,
                            input logic [XLEN-1:0] exp_v);
    if (got_v !== exp_v) begin
      abort_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got_v, exp_v));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Shadow model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] sext_low(input logic [XLEN-1:0] v);
    return {{(XLEN/2){v[XLEN/2-1]}}, v[XLEN/2-1:0]};
  endfunction

  // k is the edge at which the unit took the request
  task automatic predict_amo(input amo_req_t r, input int k, output amo_resp_t exp_v);
    logic [XLEN-1:0] old;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] ua;
    logic [XLEN-1:0] ub;
    logic [XLEN-1:0] nv;
    logic            store;
    logic            ok;
    old   = shadow[r.addr];
    a     = (r.size == SIZE_D) ? old : sext_low(old);
    b     = (r.size == SIZE_D) ? r.operand : sext_low(r.operand);
    ua    = (r.size == SIZE_D) ? old : {{(XLEN/2){1'b0}}, old[XLEN/2-1:0]};
    ub    = (r.size == SIZE_D) ? r.operand : {{(XLEN/2){1'b0}}, r.operand[XLEN/2-1:0]};
    exp_v.data = a;
    nv    = b;
    store = 1'b1;
    case (r.op)
      AMO_LR: begin
        store     = 1'b0;
        rsv_valid = 1'b1;
        rsv_addr  = r.addr;
        rsv_edge  = k;
      end
      AMO_SC: begin
        // Reservation set one edge after LR's EXEC, then lives RSV_CYCLES cycles
        ok         = rsv_valid && (rsv_addr == r.addr) && ((k - rsv_edge) <= int'(RSV_CYCLES));
        exp_v.data = ok ? 64'd0 : 64'd1;
        store      = ok;
        rsv_valid  = 1'b0;
      end
      AMO_ADD:  nv = a + b;
      AMO_AND:  nv = a & b;
      AMO_OR:   nv = a | b;
      AMO_XOR:  nv = a ^ b;
      AMO_MAX:  nv = ($signed(a) > $signed(b)) ? a : b;
      AMO_MIN:  nv = ($signed(a) < $signed(b)) ? a : b;
      AMO_MAXU: nv = (ua > ub) ? a : b;
      AMO_MINU: nv = (ua < ub) ? a : b;
      default:  nv = b;
    endcase
    if (store && r.size == SIZE_D) begin
      shadow[r.addr] = nv;
    end else if (store) begin
      shadow[r.addr][XLEN/2-1:0] = nv[XLEN/2-1:0];
    end
  endtask

  // One four-phase transfer, entered and left just after a falling edge
  task automatic run_req(input amo_req_t r, input int gap, input int hold,
                         output amo_resp_t rsp);
    amo_resp_t exp_v;
    repeat (gap) @(negedge clk_i);
    req_data_i = r;
    req_i      = 1'b1;
    // The unit takes the request on the next rising edge
    predict_amo(r, cycles + 1, exp_v);
    @(negedge clk_i);
    while (!ack_o) @(negedge clk_i);
    rsp = resp_o;
    check_resp("resp_o", rsp, exp_v);
    // Response stays put while req_i is held high
    repeat (hold) begin
      @(negedge clk_i);
      if (!ack_o) begin
        abort_run("ack_o dropped while req_i was still held high");
      end else begin
        check_resp("resp_o", resp_o, exp_v);
      end
    end
    req_i = 1'b0;
    @(negedge clk_i);
    while (ack_o) @(negedge clk_i);
  endtask

  initial begin
    req_i      = 1'b0;
    req_data_i = '0;
    rst_n_i    = 1'b0;
    rsv_valid  = 1'b0;
    rsv_addr   = '0;
    rsv_edge   = 0;
    for (int i = 0; i < int'(MEM_WORDS); i++) begin
      shadow[i] = '0;
    end
    void'($urandom(96906));
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    foreach (steps[i]) begin
      run_req(steps[i].req, steps[i].gap, steps[i].hold, got);
      check_word("resp_o.data", got.data, steps[i].exp);
    end

    // Few addresses so that LR and SC meet often
    for (int n = 0; n < N_RAND; n++) begin
      rq.op      = amo_op_e'($urandom_range(10));
      rq.size    = amo_size_e'($urandom_range(1));
      rq.addr    = ADDR_W'($urandom_range(3));
      rq.operand = {$urandom, $urandom};
      run_req(rq, $urandom_range(3), 0, got);
    end

    // Final readback of every word
    for (int a = 0; a < int'(MEM_WORDS); a++) begin
      rq = '{AMO_OR, SIZE_D, ADDR_W'(a), '0};
      run_req(rq, 0, 0, got);
      check_word("mem word", got.data, shadow[a]);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- amo_unit.f
amo_pkg.sv
amo_mem.sv
amo_alu.sv
rsv_timer.sv
amo_fsm.sv
amo_unit.sv
tb_amo_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_amo_unit -f amo_unit.f -o sim_amo_unit &&
./obj_dir/sim_amo_unit | tee /dev/stderr | grep "Result: PASSED" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
